// File: rtl/dzPkg.sv
//////////////////////////////
// Shared constants and console word layouts for the DZ11 subsystem
// Bit timing is shortened for simulation, not a real baud rate
// 8N1 framing only, no parity or modem control
//////////////////////////////

package dzPkg;

   //////////////////////////////
   // Serial timing
   //////////////////////////////

   localparam int bitCycles = 8;                    // Clocks per serial bit
   localparam int halfBit   = bitCycles / 2;        // Start bit middle
   localparam int cycW      = $clog2(bitCycles);    // Bit cycle counter
   localparam int frameBits = 10;                   // Start, 8 data, stop
   localparam int bitCntW   = $clog2(frameBits);

   // Lines and silo
   localparam int numLines  = 8;
   localparam int lineW     = $clog2(numLines);
   localparam int siloDepth = 16;
   localparam int ptrW      = $clog2(siloDepth);

   //////////////////////////////
   // Console register map
   //////////////////////////////

   localparam logic [6:0] addrCsr  = 7'h38;  // Control and status
   localparam logic [6:0] addrTdr  = 7'h39;  // Transmit data, write only
   localparam logic [6:0] addrRbuf = 7'h3a;  // Receive buffer, read pops silo

   // CSR as written by the console
   typedef struct packed {
      logic [12:0] rsvd;
      logic        masterClear;  // Self clearing
      logic        loop;         // Route lines 0 and 1 back internally
      logic        enable;       // Receive and interrupt enable
   } csrWrT;

   // TDR as written by the console
   typedef struct packed {
      logic [lineW-1:0] line;
      logic [4:0]       rsvd;
      logic [7:0]       chr;
   } tdrWrT;

   // One write word, its meaning picked by address
   typedef union packed {
      csrWrT csr;
      tdrWrT tdr;
   } dzWordT;

   // Silo entry as seen on an RBUF read
   typedef struct packed {
      logic             valid;    // Zero when the silo was empty
      logic             overrun;  // Sticky until master clear
      logic [2:0]       rsvd;
      logic [lineW-1:0] line;
      logic [7:0]       chr;
   } rbufWordT;

endpackage

// File: rtl/dzConDecode.sv
//////////////////////////////
// Console write decode
// Writes to unknown addresses are ignored
// TDR writes are not checked against busy here
//////////////////////////////

module dzConDecode (
      input  logic                        CLK50MHZ,
      input  logic                        rstN,
      input  logic                        conWr,        // One cycle strobe
      input  logic [7:1]                  conAddr,
      input  dzPkg::dzWordT               conWrData,
      output logic                        loop,
      output logic                        enable,
      output logic                        masterClear,  // One cycle pulse
      output logic [dzPkg::numLines-1:0]  txStart,      // One hot
      output logic [7:0]                  txChar
   );

   import dzPkg::*;

   logic csrWr;
   logic tdrWr;

   assign csrWr = conWr && (conAddr == addrCsr);
   assign tdrWr = conWr && (conAddr == addrTdr);

   //////////////////////////////
   // CSR bits
   //////////////////////////////

   always_ff @(posedge CLK50MHZ or negedge rstN) begin
      if (!rstN) begin
         loop        <= 1'b0;
         enable      <= 1'b0;
         masterClear <= 1'b0;
      end else begin
         masterClear <= 1'b0;                         // Pulse by default
         if (csrWr) begin
            loop        <= conWrData.csr.loop;
            enable      <= conWrData.csr.enable;
            masterClear <= conWrData.csr.masterClear;
         end
      end
   end

   //////////////////////////////
   // Transmit requests
   //////////////////////////////

   always_ff @(posedge CLK50MHZ or negedge rstN) begin
      if (!rstN) begin
         txStart <= '0;
      end else begin
         txStart <= '0;
         if (tdrWr) begin
            txStart[conWrData.tdr.line] <= 1'b1;      // Addressed line only
         end
      end
   end

   // Character rides along with the start pulse
   always_ff @(posedge CLK50MHZ) begin
      if (tdrWr) begin
         txChar <= conWrData.tdr.chr;
      end
   end

endmodule

// File: rtl/dzTransmit.sv
//////////////////////////////
// Eight 8N1 transmitters
// A start request on a busy line is dropped
// Output is idle high and comes straight from a flop
//////////////////////////////

module dzTransmit (
      input  logic                        CLK50MHZ,
      input  logic                        rstN,
      input  logic [dzPkg::numLines-1:0]  txStart,
      input  logic [7:0]                  txChar,
      output logic [dzPkg::numLines-1:0]  dzTxd,   // Serial out, LSB first
      output logic [dzPkg::numLines-1:0]  txBusy
   );

   import dzPkg::*;

   logic [frameBits-1:0] txShift [numLines];  // Bit 0 is on the wire
   logic [cycW-1:0]      txCyc   [numLines];  // Clocks into current bit
   logic [bitCntW-1:0]   txBit   [numLines];  // Bit index within frame

   //////////////////////////////
   // Per line shifter
   //////////////////////////////

   always_ff @(posedge CLK50MHZ or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < numLines; i++) begin
            txShift[i] <= '1;                       // Mark state
            txCyc[i]   <= '0;
            txBit[i]   <= '0;
            txBusy[i]  <= 1'b0;
         end
      end else begin
         for (int i = 0; i < numLines; i++) begin
            if (!txBusy[i]) begin
               if (txStart[i]) begin
                  // Stop, data, start
                  txShift[i] <= {1'b1, txChar, 1'b0};
                  txCyc[i]   <= '0;
                  txBit[i]   <= '0;
                  txBusy[i]  <= 1'b1;
               end
            end else if (txCyc[i] != cycW'(bitCycles - 1)) begin
               txCyc[i] <= txCyc[i] + 1'b1;
            end else begin
               // Bit period done, fill with ones from the top
               txCyc[i]   <= '0;
               txShift[i] <= {1'b1, txShift[i][frameBits-1:1]};
               if (txBit[i] == bitCntW'(frameBits - 1)) begin
                  txBusy[i] <= 1'b0;                // End of stop bit
               end else begin
                  txBit[i] <= txBit[i] + 1'b1;
               end
            end
         end
      end
   end

   // Wire side of each shifter
   always_comb begin
      for (int i = 0; i < numLines; i++) begin
         dzTxd[i] = txShift[i][0];
      end
   end

endmodule

// File: rtl/dzReceive.sv
//////////////////////////////
// Line routing, eight receivers, 16 entry silo, console reads
// Frames with a bad start or stop bit are discarded silently
// Full silo drops the new character and sets overrun
//////////////////////////////

module dzReceive (
      input  logic                        CLK50MHZ,
      input  logic                        rstN,
      input  logic [dzPkg::numLines-1:0]  dzTxd,
      input  logic [1:0]                  ttyTXD,       // From the pins, async
      input  logic                        loop,
      input  logic                        enable,
      input  logic                        masterClear,
      input  logic [dzPkg::numLines-1:0]  txBusy,
      input  logic                        conRd,
      input  logic [7:1]                  conAddr,
      output logic [15:0]                 conRdData,
      output logic                        conRdValid,
      output logic                        conIntrN
   );

   import dzPkg::*;

   logic [1:0]          ttyMeta, ttySync;     // Two flop synchronizer
   logic [numLines-1:0] rxLine;
   logic [numLines-1:0] rxPrev;
   logic [numLines-1:0] rxActive;
   logic [cycW-1:0]     rxCyc   [numLines];   // Down counter to next sample
   logic [bitCntW-1:0]  rxBit   [numLines];
   logic [7:0]          rxShift [numLines];
   logic [numLines-1:0] sampleNow, dataBit, stopOk;
   logic [numLines-1:0] rxPend;               // Lost arbitration last cycle
   logic [numLines-1:0] req;
   logic [lineW-1:0]    winLine;
   logic                anyReq, push, pop, full;
   logic [lineW+7:0]    siloMem [siloDepth];  // {line, char}
   logic [ptrW-1:0]     wrPtr, rdPtr;
   logic [ptrW:0]       siloCnt;
   logic                overrun;
   rbufWordT            rbufWord;

   //////////////////////////////
   // Routing
   //////////////////////////////

   always_ff @(posedge CLK50MHZ or negedge rstN) begin
      if (!rstN) begin
         ttyMeta <= '1;
         ttySync <= '1;
      end else begin
         ttyMeta <= ttyTXD;
         ttySync <= ttyMeta;
      end
   end

   // Pins only for lines 0 and 1 without loopback
   assign rxLine = loop ? dzTxd : {dzTxd[numLines-1:2], ttySync};

   //////////////////////////////
   // Receivers
   //////////////////////////////

   always_comb begin
      for (int i = 0; i < numLines; i++) begin
         sampleNow[i] = rxActive[i] && (rxCyc[i] == '0);
         dataBit[i]   = sampleNow[i] && (rxBit[i] != '0) &&
                        (rxBit[i] != bitCntW'(frameBits - 1));
         stopOk[i]    = sampleNow[i] && (rxBit[i] == bitCntW'(frameBits - 1)) && rxLine[i];
      end
   end

   always_ff @(posedge CLK50MHZ or negedge rstN) begin
      if (!rstN) begin
         rxPrev   <= '1;
         rxActive <= '0;
         for (int i = 0; i < numLines; i++) begin
            rxCyc[i] <= '0;
            rxBit[i] <= '0;
         end
      end else begin
         rxPrev <= rxLine;
         for (int i = 0; i < numLines; i++) begin
            if (!rxActive[i]) begin
               if (rxPrev[i] && !rxLine[i]) begin       // Falling edge
                  rxActive[i] <= 1'b1;
                  rxCyc[i]    <= cycW'(halfBit - 1);
                  rxBit[i]    <= '0;
               end
            end else if (rxCyc[i] != '0) begin
               rxCyc[i] <= rxCyc[i] - 1'b1;
            end else begin
               rxCyc[i] <= cycW'(bitCycles - 1);
               rxBit[i] <= rxBit[i] + 1'b1;
               if (rxBit[i] == '0 && rxLine[i]) begin
                  rxActive[i] <= 1'b0;                  // Glitch, not a start bit
               end else if (rxBit[i] == bitCntW'(frameBits - 1)) begin
                  rxActive[i] <= 1'b0;                  // Mid stop, rearm
               end
            end
         end
      end
   end

   // Held until the next frame's first data bit, well after arbitration
   always_ff @(posedge CLK50MHZ) begin
      for (int i = 0; i < numLines; i++) begin
         if (dataBit[i]) begin
            rxShift[i] <= {rxLine[i], rxShift[i][7:1]};
         end
      end
   end

   //////////////////////////////
   // Silo
   //////////////////////////////

   assign req = rxPend | stopOk;

   // Lowest line wins
   always_comb begin
      winLine = '0;
      for (int i = numLines - 1; i >= 0; i--) begin
         if (req[i]) begin
            winLine = lineW'(i);
         end
      end
   end

   assign anyReq = |req;
   assign full   = (siloCnt == (ptrW + 1)'(siloDepth));
   assign push   = anyReq && !full && !masterClear;
   assign pop    = conRd && (conAddr == addrRbuf) && (siloCnt != '0) && !masterClear;

   always_ff @(posedge CLK50MHZ or negedge rstN) begin
      if (!rstN) begin
         rxPend  <= '0;
         wrPtr   <= '0;
         rdPtr   <= '0;
         siloCnt <= '0;
         overrun <= 1'b0;
      end else if (masterClear) begin
         rxPend  <= '0;
         wrPtr   <= '0;
         rdPtr   <= '0;
         siloCnt <= '0;
         overrun <= 1'b0;
      end else begin
         for (int i = 0; i < numLines; i++) begin
            rxPend[i] <= req[i] && (winLine != lineW'(i));
         end
         if (push) wrPtr <= wrPtr + 1'b1;
         if (pop)  rdPtr <= rdPtr + 1'b1;
         case ({push, pop})
            2'b10:   siloCnt <= siloCnt + 1'b1;
            2'b01:   siloCnt <= siloCnt - 1'b1;
            default: siloCnt <= siloCnt;
         endcase
         if (anyReq && full) overrun <= 1'b1;   // Winner is lost
      end
   end

   always_ff @(posedge CLK50MHZ) begin
      if (push) begin
         siloMem[wrPtr] <= {winLine, rxShift[winLine]};
      end
   end

   //////////////////////////////
   // Console reads and interrupt
   //////////////////////////////

   always_comb begin
      rbufWord         = '0;
      rbufWord.valid   = (siloCnt != '0);
      rbufWord.overrun = overrun;
      {rbufWord.line, rbufWord.chr} = siloMem[rdPtr];
   end

   always_ff @(posedge CLK50MHZ or negedge rstN) begin
      if (!rstN) begin
         conRdValid <= 1'b0;
         conIntrN   <= 1'b1;
      end else begin
         conRdValid <= conRd;
         conIntrN   <= !(enable && (siloCnt != '0));
      end
   end

   // CSR read: txBusy, 4 zero bits, overrun, silo non empty, loop, enable
   always_ff @(posedge CLK50MHZ) begin
      if (conRd) begin
         case (conAddr)
            addrCsr:  conRdData <= {txBusy, 4'b0, overrun, siloCnt != '0, loop, enable};
            addrRbuf: conRdData <= rbufWord;
            default:  conRdData <= '0;
         endcase
      end
   end

endmodule

// File: rtl/esmDz11.sv
//////////////////////////////
// DZ11 serial subsystem top level
// Only lines 0 and 1 reach the board pins
// Console data bus is split into write and read ports
//////////////////////////////

module esmDz11 (
      // Clock and reset
      input  logic          CLK50MHZ,
      input  logic          rstN,
      input  logic          MR_N,         // Master reset push button
      output logic          MR,
      // Board serial pins
      input  logic [1:0]    ttyTXD,       // From the USB UART
      output logic [1:0]    ttyRXD,       // To the USB UART
      // Console bus
      input  logic          conWr,
      input  logic          conRd,
      input  logic [7:1]    conAddr,
      input  dzPkg::dzWordT conWrData,
      output logic [15:0]   conRdData,
      output logic          conRdValid,
      output logic          conIntrN
   );

   import dzPkg::*;

   logic                loop;
   logic                enable;
   logic                masterClear;
   logic [numLines-1:0] txStart;
   logic [7:0]          txChar;
   logic [numLines-1:0] dzTxd;
   logic [numLines-1:0] txBusy;

   //////////////////////////////
   // Decode, execute, result
   //////////////////////////////

   dzConDecode i_dzConDecode (
      .CLK50MHZ    (CLK50MHZ),
      .rstN        (rstN),
      .conWr       (conWr),
      .conAddr     (conAddr),
      .conWrData   (conWrData),
      .loop        (loop),
      .enable      (enable),
      .masterClear (masterClear),
      .txStart     (txStart),
      .txChar      (txChar)
   );

   dzTransmit i_dzTransmit (
      .CLK50MHZ (CLK50MHZ),
      .rstN     (rstN),
      .txStart  (txStart),
      .txChar   (txChar),
      .dzTxd    (dzTxd),
      .txBusy   (txBusy)
   );

   dzReceive i_dzReceive (
      .CLK50MHZ    (CLK50MHZ),
      .rstN        (rstN),
      .dzTxd       (dzTxd),
      .ttyTXD      (ttyTXD),
      .loop        (loop),
      .enable      (enable),
      .masterClear (masterClear),
      .txBusy      (txBusy),
      .conRd       (conRd),
      .conAddr     (conAddr),
      .conRdData   (conRdData),
      .conRdValid  (conRdValid),
      .conIntrN    (conIntrN)
   );

   // UART TXD feeds our RX side, so the pins are twisted here
   assign ttyRXD = dzTxd[1:0];

   assign MR = !MR_N;   // Push button level only

endmodule

// File: verification/esmDz11_chk.sv
//////////////////////////////
// Protocol checks bound into the top level
// Uses the internal txBusy bus of the top level
//////////////////////////////

module esmDz11_chk (
      input logic       CLK50MHZ,
      input logic       rstN,
      input logic       conRd,
      input logic       conRdValid,
      input logic       conIntrN,
      input logic [1:0] ttyRXD,
      input logic [7:0] txBusy
   );
   timeunit 1ns;
   timeprecision 100ps;

   // Read response exactly one cycle after the strobe
   assert property (@(posedge CLK50MHZ) disable iff (!rstN)
      conRd |=> conRdValid)
      else $error("read strobe without a response one cycle later");

   assert property (@(posedge CLK50MHZ) disable iff (!rstN)
      conRdValid |-> $past(conRd))
      else $error("read response without a strobe");

   // Outputs quiet once reset has been seen by a clock edge
   assert property (@(posedge CLK50MHZ)
      !rstN |=> (!conRdValid && conIntrN))
      else $error("console outputs active during reset");

   // Idle lines hold mark
   assert property (@(posedge CLK50MHZ) disable iff (!rstN)
      !txBusy[0] |-> ttyRXD[0])
      else $error("ttyRXD[0] low while line 0 idle");

   assert property (@(posedge CLK50MHZ) disable iff (!rstN)
      !txBusy[1] |-> ttyRXD[1])
      else $error("ttyRXD[1] low while line 1 idle");

endmodule

bind esmDz11 esmDz11_chk i_esmDz11_chk (
   .CLK50MHZ   (CLK50MHZ),
   .rstN       (rstN),
   .conRd      (conRd),
   .conRdValid (conRdValid),
   .conIntrN   (conIntrN),
   .ttyRXD     (ttyRXD),
   .txBusy     (txBusy)
);

// File: verification/tbEsmDz11.sv
//////////////////////////////
// Testbench for the DZ11 subsystem top level
// Drives the console bus and the ttyTXD pins on the falling edge
// Expects one character in flight per line at a time
//////////////////////////////

module tbEsmDz11;
   timeunit 1ns;
   timeprecision 100ps;

   import dzPkg::*;

   localparam int frameCycles = 10 * bitCycles;           // One 8N1 frame
   localparam int pollLimit   = 4 * frameCycles;          // CSR polls before giving up
   localparam int loopChars   = 6;
   localparam int fillChars   = 17;                       // One past a full silo
   localparam longint watchdogNs = longint'(40 * frameCycles + 1000) * 100;

   logic        CLK50MHZ = 1'b0;
   logic        rstN     = 1'b0;
   logic        MR_N     = 1'b1;
   logic        MR;
   logic [1:0]  ttyTXD   = 2'b11;                         // Idle mark
   logic [1:0]  ttyRXD;
   logic        conWr    = 1'b0;
   logic        conRd    = 1'b0;
   logic [6:0]  conAddr  = '0;
   logic [15:0] conWrData = '0;
   logic [15:0] conRdData;
   logic        conRdValid;
   logic        conIntrN;

   logic [31:0] lcgState = 32'd86;
   logic [15:0] expQ[$];                                  // Expected read words
   logic [15:0] maskQ[$];                                 // Bits that matter
   logic [10:0] siloModel[$];                             // {line, char}
   logic [7:0]  txExp0[$];
   logic [7:0]  txExp1[$];
   logic        enModel  = 1'b0;
   logic        ovrModel = 1'b0;

   esmDz11 i_esmDz11 (.*);

   always #50 CLK50MHZ = ~CLK50MHZ;

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic logic [7:0] nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[23:16];
   endfunction

   task automatic stopOnError();
      $display("Verification failed");
      $fatal(1);
   endtask

   // MR is only the inverted push button
   task automatic driveButton(input logic buttonN, input logic expMr);
      @(negedge CLK50MHZ);
      MR_N = buttonN;
      @(negedge CLK50MHZ);
      assert (MR == expMr) else begin
         $display("error MR expected %h got %h", expMr, MR);
         stopOnError();
      end
   endtask

   task automatic writeReg(input logic [6:0] a, input logic [15:0] d);
      @(negedge CLK50MHZ);
      conWr     = 1'b1;
      conAddr   = a;
      conWrData = d;
      @(negedge CLK50MHZ);
      conWr     = 1'b0;
   endtask

   // Data is valid one cycle after the strobe
   task automatic readReg(input logic [6:0] a, input logic [15:0] e,
                          input logic [15:0] m, output logic [15:0] d);
      expQ.push_back(e);
      maskQ.push_back(m);
      @(negedge CLK50MHZ);
      conRd   = 1'b1;
      conAddr = a;
      @(negedge CLK50MHZ);
      conRd   = 1'b0;
      d       = conRdData;
   endtask

   task automatic writeCsr(input logic en, input logic lp, input logic mc);
      enModel = en;
      if (mc) begin
         siloModel.delete();
         ovrModel = 1'b0;
      end
      writeReg(addrCsr, {13'b0, mc, lp, en});
   endtask

   // Model follows the silo rule, lines 0 and 1 also show on the pins
   task automatic sendChar(input logic [2:0] ln, input logic [7:0] c, input logic rxExp);
      if (rxExp) begin
         if (siloModel.size() < siloDepth) siloModel.push_back({ln, c});
         else ovrModel = 1'b1;                            // New one is lost
      end
      if (ln == 3'd0) txExp0.push_back(c);
      if (ln == 3'd1) txExp1.push_back(c);
      writeReg(addrTdr, {ln, 5'b0, c});
   endtask

   task automatic waitIdle(input int ln);
      logic [15:0] w;
      int n;
      n = 0;
      repeat (3) @(negedge CLK50MHZ);                    // Let busy rise first
      readReg(addrCsr, '0, '0, w);
      while (w[8 + ln]) begin
         n++;
         assert (n < pollLimit) else begin
            $display("transmitter on line %0d never went idle", ln);
            stopOnError();
         end
         readReg(addrCsr, '0, '0, w);
      end
   endtask

   // Interrupt follows the silo one cycle late, masterClear adds one more
   task automatic checkIntr();
      repeat (2) @(negedge CLK50MHZ);
      assert (conIntrN == !(enModel && siloModel.size() != 0)) else begin
         $display("error conIntrN expected %h got %h",
                  !(enModel && siloModel.size() != 0), conIntrN);
         stopOnError();
      end
   endtask

   task automatic readChar();
      logic [15:0] w;
      logic [10:0] lc;
      int n;
      n = 0;
      readReg(addrCsr, '0, '0, w);
      while (!w[2]) begin                                 // Silo non empty
         n++;
         assert (n < pollLimit) else begin
            $display("no character reached the silo in time");
            stopOnError();
         end
         readReg(addrCsr, '0, '0, w);
      end
      lc = siloModel.pop_front();
      readReg(addrRbuf, {1'b1, ovrModel, 3'b0, lc}, 16'hffff, w);
      checkIntr();
   endtask

   task automatic driveFrame(input int ln, input logic [7:0] c);
      logic [9:0] bits;
      bits = {1'b1, c, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(negedge CLK50MHZ);
         ttyTXD[ln] = bits[i];
         repeat (bitCycles - 1) @(negedge CLK50MHZ);
      end
   endtask

   //////////////////////////////
   // Serial monitor on ttyRXD
   //////////////////////////////

   task automatic monitorLine(input int ln);
      logic [7:0] c;
      logic [7:0] e;
      forever begin
         @(negedge CLK50MHZ);
         if (rstN && !ttyRXD[ln]) begin
            repeat (bitCycles / 2 - 1) @(negedge CLK50MHZ);  // Middle of start
            assert (!ttyRXD[ln]) else begin
               $display("start bit too short on ttyRXD[%0d]", ln);
               stopOnError();
            end
            for (int i = 0; i < 8; i++) begin
               repeat (bitCycles) @(negedge CLK50MHZ);
               c[i] = ttyRXD[ln];                       // LSB first
            end
            repeat (bitCycles) @(negedge CLK50MHZ);
            assert (ttyRXD[ln]) else begin
               $display("stop bit missing on ttyRXD[%0d]", ln);
               stopOnError();
            end
            assert ((ln == 0 ? txExp0.size() : txExp1.size()) != 0) else begin
               $display("unexpected frame on ttyRXD[%0d]", ln);
               stopOnError();
            end
            e = (ln == 0) ? txExp0.pop_front() : txExp1.pop_front();
            assert (c == e) else begin
               $display("error ttyRXD[%0d] expected %h got %h", ln, e, c);
               stopOnError();
            end
         end
      end
   endtask

   initial begin
      fork
         monitorLine(0);
         monitorLine(1);
      join
   end

   // Every read response against the head of the expected queue
   always @(negedge CLK50MHZ) begin : rdCheck
      logic [15:0] e;
      logic [15:0] m;
      if (rstN && conRdValid) begin
         assert (expQ.size() != 0) else begin
            $display("read response with no read pending");
            stopOnError();
         end
         e = expQ.pop_front();
         m = maskQ.pop_front();
         assert ((conRdData & m) == (e & m)) else begin
            $display("error conRdData expected %h got %h mask %h", e, conRdData, m);
            stopOnError();
         end
      end
   end

   initial begin
      #(watchdogNs);
      $display("watchdog expired before the tests finished");
      $display("Verification failed");
      $fatal(1);
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial begin : stimulus
      logic [15:0] w;
      logic [2:0]  ln;
      logic [7:0]  c;
      repeat (16) @(negedge CLK50MHZ);
      rstN = 1'b1;
      checkIntr();
      driveButton(1'b0, 1'b1);
      driveButton(1'b1, 1'b0);

      // Loopback on lines 2 to 7
      writeCsr(1'b1, 1'b1, 1'b0);
      for (int k = 0; k < loopChars; k++) begin
         ln = 3'(2 + nextRand() % 6);
         sendChar(ln, nextRand(), 1'b1);
         readChar();
      end

      // Pins without loopback
      writeCsr(1'b1, 1'b0, 1'b0);
      sendChar(3'd0, nextRand(), 1'b0);
      sendChar(3'd1, nextRand(), 1'b0);
      waitIdle(0);
      waitIdle(1);
      c = nextRand();
      siloModel.push_back({3'd1, c});
      driveFrame(1, c);
      readChar();

      // Loopback hides the pins
      writeCsr(1'b1, 1'b1, 1'b0);
      driveFrame(0, nextRand());
      repeat (2 * bitCycles) @(negedge CLK50MHZ);
      readReg(addrCsr, 16'h0000, 16'h0004, w);
      sendChar(3'd0, nextRand(), 1'b1);
      sendChar(3'd1, nextRand(), 1'b1);
      readChar();
      readChar();

      // Second write to a busy line
      ln = 3'(2 + nextRand() % 6);
      sendChar(ln, nextRand(), 1'b1);
      writeReg(addrTdr, {ln, 5'b0, nextRand()});          // Dropped by DUT
      readChar();
      waitIdle(ln);
      repeat (frameCycles) @(negedge CLK50MHZ);
      readReg(addrCsr, 16'h0000, 16'h0004, w);

      // Overrun, then master clear
      writeCsr(1'b0, 1'b1, 1'b0);
      for (int k = 0; k < fillChars; k++) begin
         ln = 3'(2 + k % 6);
         sendChar(ln, nextRand(), 1'b1);
         waitIdle(ln);
         // Overrun stays clear until the 17th character
         readReg(addrCsr, {12'b0, ovrModel, siloModel.size() != 0, 2'b00}, 16'h000c, w);
      end
      checkIntr();
      readReg(addrCsr, 16'h000c, 16'h000c, w);
      readChar();                                         // Oldest kept one
      writeCsr(1'b1, 1'b1, 1'b0);
      checkIntr();
      writeCsr(1'b1, 1'b1, 1'b1);
      checkIntr();
      readReg(addrRbuf, 16'h0000, 16'hc000, w);

      repeat (frameCycles) @(negedge CLK50MHZ);
      if (txExp0.size() == 0 && txExp1.size() == 0 && expQ.size() == 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("characters written but never seen on the pins or read back");
         stopOnError();
      end
   end

endmodule

// File: project.f
rtl/dzPkg.sv
rtl/dzConDecode.sv
rtl/dzTransmit.sv
rtl/dzReceive.sv
rtl/esmDz11.sv
verification/esmDz11_chk.sv
verification/tbEsmDz11.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the DZ11 testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tbEsmDz11 \
   -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "Simulation returned status $simStatus"
   exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
   echo "Simulation ended without a result"
   exit 1
fi
exit 0
